// ==== hdl/lsq_load_align.sv ====
`timescale 1ns/1ps
`include "lsq_params.svh"

module lsq_load_align
    import lsq_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_done,
    input  logic [`ROB_TAG_W-1:0] head_rob_tag,
    input  logic [`XLEN-1:0]      head_addr,
    input  logic [1:0]            head_size,
    input  logic                  head_unsigned,
    input  dcache_line_t          dcache_data_out,
    output logic                  load_valid,
    output logic [`ROB_TAG_W-1:0] load_tag,
    output logic [`XLEN-1:0]      load_value
);

    logic [7:0]       lane_byte;
    logic [15:0]      lane_half;
    logic [`XLEN-1:0] value_next;

    // lanes picked by the offset within the line
    assign lane_byte = dcache_data_out.bytes[head_addr[2:0]];
    assign lane_half = dcache_data_out.halves[head_addr[2:1]];

    always_comb begin
        case (head_size)
            `MEM_BYTE:
                value_next = {{(`XLEN-8){lane_byte[7] && !head_unsigned}}, lane_byte};
            `MEM_HALF:
                value_next = {{(`XLEN-16){lane_half[15] && !head_unsigned}}, lane_half};
            // word fills XLEN, no extension
            default:
                value_next = dcache_data_out.words[head_addr[2]];
        endcase
    end

    // one-cycle broadcast pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= load_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_done) begin
            load_tag   <= head_rob_tag;
            load_value <= value_next;
        end
    end

endmodule

// ==== hdl/lsq_mem_issue.sv ====
`timescale 1ns/1ps
`include "lsq_params.svh"

module lsq_mem_issue
    import lsq_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // head entry
    input  logic                  head_valid,
    input  logic                  head_is_store,
    input  logic                  head_addr_valid,
    input  logic                  head_data_valid,
    input  logic                  head_retired,
    input  logic [`ROB_TAG_W-1:0] head_rob_tag,
    input  logic [`XLEN-1:0]      head_addr,
    input  logic [1:0]            head_size,
    input  logic [`XLEN-1:0]      head_store_data,
    // data cache reply
    input  logic [`DC_TAG_W-1:0]  dcache_response,
    input  logic                  dcache_hit,
    input  logic [`DC_TAG_W-1:0]  dcache_tag,
    // data cache request
    output logic [1:0]            dcache_command,
    output logic [`XLEN-1:0]      dcache_addr,
    output logic [1:0]            dcache_size,
    output dcache_line_t          dcache_data,
    // completion
    output logic                  pop,
    output logic                  load_done,
    output logic                  store_ready,
    output logic [`ROB_TAG_W-1:0] store_ready_tag
);

    logic                 miss_pending;
    logic [`DC_TAG_W-1:0] miss_tag;
    logic                 load_go;
    logic                 store_go;
    logic                 accepted;
    logic                 miss_return;

    // a load waits only for its address, and nothing goes out under a miss
    assign load_go = head_valid && !head_is_store && head_addr_valid && !miss_pending;
    // a store also needs its data and the retire pulse
    assign store_go = head_valid && head_is_store && head_addr_valid
                      && head_data_valid && head_retired;

    // ROB sees the store once it could write
    assign store_ready = head_valid && head_is_store && head_addr_valid && head_data_valid;
    assign store_ready_tag = head_rob_tag;

    always_comb begin
        dcache_command = `BUS_NONE;
        dcache_addr    = '0;
        dcache_size    = '0;
        dcache_data    = '0;
        if (store_go) begin
            dcache_command = `BUS_STORE;
            dcache_addr    = head_addr;
            dcache_size    = head_size;
            // store word in the low half, upper word stays zero
            dcache_data.words[0] = head_store_data;
        end else if (load_go) begin
            dcache_command = `BUS_LOAD;
            dcache_addr    = head_addr;
            dcache_size    = head_size;
        end
    end

    assign accepted = dcache_hit || (dcache_response != '0);
    assign miss_return = miss_pending && (dcache_tag != '0) && (dcache_tag == miss_tag);

    assign load_done = (load_go && dcache_hit) || miss_return;
    assign pop = load_done || (store_go && dcache_response != '0);

    // blocking miss tracking, the load stays at the head meanwhile
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            miss_pending <= 1'b0;
            miss_tag     <= '0;
        end else if (miss_return) begin
            miss_pending <= 1'b0;
        end else if (load_go && !dcache_hit && dcache_response != '0) begin
            miss_pending <= 1'b1;
            miss_tag     <= dcache_response;
        end
    end

    // the cache returns a tag only for a miss it accepted from us
    assert property (@(posedge clk) disable iff (reset) (dcache_tag != '0) |-> miss_pending)
        else $error("dcache_tag without a pending miss");

    // a refused request is held until the cache takes it
    assert property (@(posedge clk) disable iff (reset)
        (dcache_command != `BUS_NONE && !accepted)
            |=> $stable(dcache_command) && $stable(dcache_addr)
                && $stable(dcache_size) && $stable(dcache_data))
        else $error("request changed before acceptance");

endmodule

// ==== hdl/lsq_mem_pkg.sv ====
`include "lsq_params.svh"

package lsq_mem_pkg;

    // lane counts within one cache line
    localparam int LINE_WORDS = `LINE_W / 32;
    localparam int LINE_HALVES = `LINE_W / 16;
    localparam int LINE_BYTES = `LINE_W / 8;

    // one cache line, indexed as words, halves or bytes
    // lane 0 is always the least significant part of the line
    typedef union packed {
        logic [LINE_WORDS-1:0][31:0] words;
        logic [LINE_HALVES-1:0][15:0] halves;
        logic [LINE_BYTES-1:0][7:0] bytes;
    } dcache_line_t;

endpackage

// ==== hdl/lsq_params.svh ====
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// data and address width
`define XLEN 32
// one data cache line
`define LINE_W 64

// queue geometry, pointers carry one extra wrap bit
`define LSQ_DEPTH 8
`define LSQ_PTR_W 4

// ROB tags are shared with the CDB
`define ROB_TAG_W 5
// cache transaction tag, zero means no transaction
`define DC_TAG_W 4

// data cache bus commands
`define BUS_NONE  2'b00
`define BUS_LOAD  2'b01
`define BUS_STORE 2'b10

// access sizes
`define MEM_BYTE 2'b00
`define MEM_HALF 2'b01
`define MEM_WORD 2'b10

`endif

// ==== hdl/lsq_queue.sv ====
`timescale 1ns/1ps
`include "lsq_params.svh"

module lsq_queue (
    input  logic                  clk,
    input  logic                  reset,
    // new entry from issue
    input  logic                  enq_valid,
    input  logic                  enq_is_store,
    input  logic [`ROB_TAG_W-1:0] enq_rob_tag,
    input  logic [1:0]            enq_size,
    input  logic                  enq_unsigned,
    input  logic                  enq_data_valid,
    input  logic [`XLEN-1:0]      enq_data,
    input  logic [`ROB_TAG_W-1:0] enq_data_tag,
    // capture pulses
    input  logic                  addr_valid,
    input  logic [`ROB_TAG_W-1:0] addr_tag,
    input  logic [`XLEN-1:0]      addr,
    input  logic                  cdb_valid,
    input  logic [`ROB_TAG_W-1:0] cdb_tag,
    input  logic [`XLEN-1:0]      cdb_value,
    input  logic                  retire_valid,
    input  logic [`ROB_TAG_W-1:0] retire_tag,
    // head done, from issue
    input  logic                  pop,
    output logic                  lsq_free,
    // head entry fields
    output logic                  head_valid,
    output logic                  head_is_store,
    output logic                  head_addr_valid,
    output logic                  head_data_valid,
    output logic                  head_retired,
    output logic [`ROB_TAG_W-1:0] head_rob_tag,
    output logic [`XLEN-1:0]      head_addr,
    output logic [1:0]            head_size,
    output logic                  head_unsigned,
    output logic [`XLEN-1:0]      head_store_data
);

    localparam int IDX_W = `LSQ_PTR_W - 1;

    // entry state flags
    logic [`LSQ_DEPTH-1:0] ent_valid;
    logic [`LSQ_DEPTH-1:0] ent_is_store;
    logic [`LSQ_DEPTH-1:0] ent_addr_valid;
    logic [`LSQ_DEPTH-1:0] ent_data_valid;
    logic [`LSQ_DEPTH-1:0] ent_retired;

    // entry payload
    logic [`ROB_TAG_W-1:0] ent_rob_tag [`LSQ_DEPTH];
    logic [`ROB_TAG_W-1:0] ent_data_tag [`LSQ_DEPTH];
    logic [`XLEN-1:0]      ent_addr [`LSQ_DEPTH];
    logic [`XLEN-1:0]      ent_data [`LSQ_DEPTH];
    logic [1:0]            ent_size [`LSQ_DEPTH];
    logic                  ent_unsigned [`LSQ_DEPTH];

    logic [`LSQ_PTR_W-1:0] head_ptr;
    logic [`LSQ_PTR_W-1:0] tail_ptr;
    logic [IDX_W-1:0]      head_idx;
    logic [IDX_W-1:0]      tail_idx;
    logic                  full;

    assign head_idx = head_ptr[IDX_W-1:0];
    assign tail_idx = tail_ptr[IDX_W-1:0];

    // same slot on different laps means every entry is taken
    assign full = (head_idx == tail_idx) && (head_ptr[IDX_W] != tail_ptr[IDX_W]);
    assign lsq_free = !full;

    assign head_valid      = ent_valid[head_idx];
    assign head_is_store   = ent_is_store[head_idx];
    assign head_addr_valid = ent_addr_valid[head_idx];
    assign head_data_valid = ent_data_valid[head_idx];
    assign head_retired    = ent_retired[head_idx];
    assign head_rob_tag    = ent_rob_tag[head_idx];
    assign head_addr       = ent_addr[head_idx];
    assign head_size       = ent_size[head_idx];
    assign head_unsigned   = ent_unsigned[head_idx];
    assign head_store_data = ent_data[head_idx];

    // pointers and flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_ptr       <= '0;
            tail_ptr       <= '0;
            ent_valid      <= '0;
            ent_is_store   <= '0;
            ent_addr_valid <= '0;
            ent_data_valid <= '0;
            ent_retired    <= '0;
        end else begin
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                // address from execute, matched by ROB tag
                if (addr_valid && ent_valid[i] && !ent_addr_valid[i]
                        && ent_rob_tag[i] == addr_tag) begin
                    ent_addr_valid[i] <= 1'b1;
                end
                // store data from the CDB, matched by producer tag
                if (cdb_valid && ent_valid[i] && ent_is_store[i] && !ent_data_valid[i]
                        && ent_data_tag[i] == cdb_tag) begin
                    ent_data_valid[i] <= 1'b1;
                end
                if (retire_valid && ent_valid[i] && ent_is_store[i] && !ent_retired[i]
                        && ent_rob_tag[i] == retire_tag) begin
                    ent_retired[i] <= 1'b1;
                end
            end
            if (pop) begin
                ent_valid[head_idx] <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end
            // never the head slot while it pops, the queue cannot be full then
            if (enq_valid) begin
                ent_valid[tail_idx]      <= 1'b1;
                ent_is_store[tail_idx]   <= enq_is_store;
                ent_addr_valid[tail_idx] <= 1'b0;
                // loads count as having data
                ent_data_valid[tail_idx] <= enq_data_valid || !enq_is_store;
                ent_retired[tail_idx]    <= 1'b0;
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

    // payload follows the same matches
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (addr_valid && ent_valid[i] && !ent_addr_valid[i]
                    && ent_rob_tag[i] == addr_tag) begin
                ent_addr[i] <= addr;
            end
            if (cdb_valid && ent_valid[i] && ent_is_store[i] && !ent_data_valid[i]
                    && ent_data_tag[i] == cdb_tag) begin
                ent_data[i] <= cdb_value;
            end
        end
        if (enq_valid) begin
            ent_rob_tag[tail_idx]  <= enq_rob_tag;
            ent_data_tag[tail_idx] <= enq_data_tag;
            ent_data[tail_idx]     <= enq_data;
            ent_size[tail_idx]     <= enq_size;
            ent_unsigned[tail_idx] <= enq_unsigned;
        end
    end

    // issue must watch lsq_free before it enqueues
    assert property (@(posedge clk) disable iff (reset) enq_valid |-> lsq_free)
        else $error("enqueue while the LSQ is full");

endmodule

// ==== hdl/lsq_top.sv ====
`timescale 1ns/1ps
`include "lsq_params.svh"

module lsq_top
    import lsq_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // enqueue from issue
    input  logic                  enq_valid,
    input  logic                  enq_is_store,
    input  logic [`ROB_TAG_W-1:0] enq_rob_tag,
    input  logic [1:0]            enq_size,
    input  logic                  enq_unsigned,
    input  logic                  enq_data_valid,
    input  logic [`XLEN-1:0]      enq_data,
    input  logic [`ROB_TAG_W-1:0] enq_data_tag,
    output logic                  lsq_free,
    // address from execute
    input  logic                  addr_valid,
    input  logic [`ROB_TAG_W-1:0] addr_tag,
    input  logic [`XLEN-1:0]      addr,
    // store data from the CDB
    input  logic                  cdb_valid,
    input  logic [`ROB_TAG_W-1:0] cdb_tag,
    input  logic [`XLEN-1:0]      cdb_value,
    // retire stage
    input  logic                  retire_valid,
    input  logic [`ROB_TAG_W-1:0] retire_tag,
    // data cache request
    output logic [1:0]            dcache_command,
    output logic [`XLEN-1:0]      dcache_addr,
    output logic [1:0]            dcache_size,
    output dcache_line_t          dcache_data,
    // data cache reply
    input  logic [`DC_TAG_W-1:0]  dcache_response,
    input  logic                  dcache_hit,
    input  logic [`DC_TAG_W-1:0]  dcache_tag,
    input  dcache_line_t          dcache_data_out,
    // results
    output logic                  load_valid,
    output logic [`ROB_TAG_W-1:0] load_tag,
    output logic [`XLEN-1:0]      load_value,
    output logic                  store_ready,
    output logic [`ROB_TAG_W-1:0] store_ready_tag
);

    // head entry as seen by issue and load result
    logic                  head_valid;
    logic                  head_is_store;
    logic                  head_addr_valid;
    logic                  head_data_valid;
    logic                  head_retired;
    logic [`ROB_TAG_W-1:0] head_rob_tag;
    logic [`XLEN-1:0]      head_addr;
    logic [1:0]            head_size;
    logic                  head_unsigned;
    logic [`XLEN-1:0]      head_store_data;

    logic pop;
    logic load_done;

    lsq_queue u_queue (
        .clk             (clk),
        .reset           (reset),
        .enq_valid       (enq_valid),
        .enq_is_store    (enq_is_store),
        .enq_rob_tag     (enq_rob_tag),
        .enq_size        (enq_size),
        .enq_unsigned    (enq_unsigned),
        .enq_data_valid  (enq_data_valid),
        .enq_data        (enq_data),
        .enq_data_tag    (enq_data_tag),
        .addr_valid      (addr_valid),
        .addr_tag        (addr_tag),
        .addr            (addr),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .retire_valid    (retire_valid),
        .retire_tag      (retire_tag),
        .pop             (pop),
        .lsq_free        (lsq_free),
        .head_valid      (head_valid),
        .head_is_store   (head_is_store),
        .head_addr_valid (head_addr_valid),
        .head_data_valid (head_data_valid),
        .head_retired    (head_retired),
        .head_rob_tag    (head_rob_tag),
        .head_addr       (head_addr),
        .head_size       (head_size),
        .head_unsigned   (head_unsigned),
        .head_store_data (head_store_data)
    );

    lsq_mem_issue u_issue (
        .clk             (clk),
        .reset           (reset),
        .head_valid      (head_valid),
        .head_is_store   (head_is_store),
        .head_addr_valid (head_addr_valid),
        .head_data_valid (head_data_valid),
        .head_retired    (head_retired),
        .head_rob_tag    (head_rob_tag),
        .head_addr       (head_addr),
        .head_size       (head_size),
        .head_store_data (head_store_data),
        .dcache_response (dcache_response),
        .dcache_hit      (dcache_hit),
        .dcache_tag      (dcache_tag),
        .dcache_command  (dcache_command),
        .dcache_addr     (dcache_addr),
        .dcache_size     (dcache_size),
        .dcache_data     (dcache_data),
        .pop             (pop),
        .load_done       (load_done),
        .store_ready     (store_ready),
        .store_ready_tag (store_ready_tag)
    );

    lsq_load_align u_align (
        .clk             (clk),
        .reset           (reset),
        .load_done       (load_done),
        .head_rob_tag    (head_rob_tag),
        .head_addr       (head_addr),
        .head_size       (head_size),
        .head_unsigned   (head_unsigned),
        .dcache_data_out (dcache_data_out),
        .load_valid      (load_valid),
        .load_tag        (load_tag),
        .load_value      (load_value)
    );

endmodule

// ==== list.f ====
+incdir+hdl
hdl/lsq_mem_pkg.sv
hdl/lsq_queue.sv
hdl/lsq_mem_issue.sv
hdl/lsq_load_align.sv
hdl/lsq_top.sv
tb/lsq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the LSQ testbench with Verilator, run it and search the log
verilator --binary --timing --assert -Wno-fatal --top-module lsq_tb -f list.f -o lsq_sim \
    && { ./obj_dir/lsq_sim > sim.log 2>&1; cat sim.log; } \
    && grep -q "^Simulation PASSED$" sim.log \
    && echo "run_sim: ok" \
    || { echo "run_sim: failing run, see sim.log"; exit 1; }

// ==== tb/lsq_tb.sv ====
`timescale 1ns/1ps
`include "lsq_params.svh"

module lsq_tb
    import lsq_mem_pkg::*;
();

    localparam int TRACE_COLS = 10;
    localparam int TRACE_OPS  = 64;
    localparam int TIMEOUT    = 50;

    // trace operation kinds
    localparam int OP_END   = 0;
    localparam int OP_LOAD  = 1;
    localparam int OP_STORE = 2;
    localparam int OP_SERVE = 3;

    logic                  clk;
    logic                  reset;
    logic                  enq_valid;
    logic                  enq_is_store;
    logic [`ROB_TAG_W-1:0] enq_rob_tag;
    logic [1:0]            enq_size;
    logic                  enq_unsigned;
    logic                  enq_data_valid;
    logic [`XLEN-1:0]      enq_data;
    logic [`ROB_TAG_W-1:0] enq_data_tag;
    logic                  lsq_free;
    logic                  addr_valid;
    logic [`ROB_TAG_W-1:0] addr_tag;
    logic [`XLEN-1:0]      addr;
    logic                  cdb_valid;
    logic [`ROB_TAG_W-1:0] cdb_tag;
    logic [`XLEN-1:0]      cdb_value;
    logic                  retire_valid;
    logic [`ROB_TAG_W-1:0] retire_tag;
    logic [1:0]            dcache_command;
    logic [`XLEN-1:0]      dcache_addr;
    logic [1:0]            dcache_size;
    dcache_line_t          dcache_data;
    logic [`DC_TAG_W-1:0]  dcache_response;
    logic                  dcache_hit;
    logic [`DC_TAG_W-1:0]  dcache_tag;
    dcache_line_t          dcache_data_out;
    logic                  load_valid;
    logic [`ROB_TAG_W-1:0] load_tag;
    logic [`XLEN-1:0]      load_value;
    logic                  store_ready;
    logic [`ROB_TAG_W-1:0] store_ready_tag;

    // trace image with one word per column
    logic [63:0] trace_mem [TRACE_OPS*TRACE_COLS];
    // indices of enqueued operations in age order
    int pending [$];
    logic [15:0] lfsr_state;
    // cache transaction tags run 1..15
    logic [`DC_TAG_W-1:0] next_dc_tag;

    // operation currently being enqueued or served
    int                    op_kind;
    logic [`ROB_TAG_W-1:0] op_rob;
    logic [`XLEN-1:0]      op_addr;
    logic [1:0]            op_size;
    logic                  op_unsigned;
    logic [`XLEN-1:0]      op_sdata;
    logic [`ROB_TAG_W-1:0] op_dtag;
    dcache_line_t          op_line;
    logic                  op_hit;
    logic [63:0]           op_expect;

    lsq_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one LFSR step per bit
    task automatic draw_bits(input int n, output int value);
        int k;
        value = 0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_advance(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        stop_with_failure($sformatf("MISMATCH at %0d ns: %s", $time, what));
    endtask

    task automatic tick();
        @(negedge clk);
    endtask

    task automatic advance_dc_tag();
        next_dc_tag = (next_dc_tag == 4'hf) ? 4'h1 : next_dc_tag + 4'h1;
    endtask

    task automatic fetch_op(input int op);
        logic [63:0] col [TRACE_COLS];
        for (int c = 0; c < TRACE_COLS; c++) begin
            col[c] = trace_mem[op*TRACE_COLS + c];
        end
        op_kind     = int'(col[0][31:0]);
        op_rob      = col[1][`ROB_TAG_W-1:0];
        op_addr     = col[2][`XLEN-1:0];
        op_size     = col[3][1:0];
        op_unsigned = col[4][0];
        op_sdata    = col[5][`XLEN-1:0];
        op_dtag     = col[6][`ROB_TAG_W-1:0];
        op_line     = col[7];
        op_hit      = col[8][0];
        op_expect   = col[9];
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", name, actual, expected));
        end
    endtask

    task automatic check_idle(input string when);
        if (dcache_command !== `BUS_NONE) begin
            report_mismatch($sformatf("command %b %s", dcache_command, when));
        end
    endtask

    task automatic check_load(input logic [`ROB_TAG_W-1:0] exp_tag,
                              input logic [`XLEN-1:0] exp_value);
        if (load_valid !== 1'b1) begin
            report_mismatch($sformatf("no load broadcast for ROB tag %h", exp_tag));
        end else if (load_tag !== exp_tag) begin
            report_mismatch($sformatf("load tag %h, expected %h", load_tag, exp_tag));
        end else if (load_value !== exp_value) begin
            report_mismatch($sformatf("load value %h, expected %h", load_value, exp_value));
        end
    endtask

    task automatic check_request(input logic [1:0] exp_cmd, input logic [`XLEN-1:0] exp_addr,
                                 input logic [1:0] exp_size, input dcache_line_t exp_data,
                                 input logic with_data);
        if (dcache_command !== exp_cmd) begin
            report_mismatch($sformatf("command %b, expected %b", dcache_command, exp_cmd));
        end else if (dcache_addr !== exp_addr) begin
            report_mismatch($sformatf("address %h, expected %h", dcache_addr, exp_addr));
        end else if (dcache_size !== exp_size) begin
            report_mismatch($sformatf("size %b, expected %b", dcache_size, exp_size));
        end else if (with_data && dcache_data !== exp_data) begin
            report_mismatch($sformatf("store line %h, expected %h", dcache_data, exp_data));
        end
    endtask

    task automatic check_store_ready(input logic [`ROB_TAG_W-1:0] exp_tag);
        if (store_ready !== 1'b1) begin
            report_mismatch($sformatf("store_ready low for ROB tag %h", exp_tag));
        end else if (store_ready_tag !== exp_tag) begin
            report_mismatch($sformatf("store_ready_tag %h, expected %h",
                                      store_ready_tag, exp_tag));
        end
    endtask

    task automatic wait_request(input string what);
        int n;
        n = 0;
        while (dcache_command === `BUS_NONE) begin
            if (n == TIMEOUT) begin
                stop_with_failure($sformatf("timeout at %0d ns waiting for %s", $time, what));
            end
            tick();
            n++;
        end
    endtask

    task automatic wait_store_ready();
        int n;
        n = 0;
        while (store_ready !== 1'b1) begin
            if (n == TIMEOUT) begin
                stop_with_failure($sformatf("timeout at %0d ns waiting for store_ready", $time));
            end
            tick();
            n++;
        end
    endtask

    // cache refuses for a random number of cycles while the request must not move
    task automatic hold_request(input logic [1:0] cmd, input dcache_line_t line,
                                input logic with_data);
        int stall;
        draw_bits(2, stall);
        repeat (stall) begin
            tick();
            check_request(cmd, op_addr, op_size, line, with_data);
        end
    endtask

    task automatic enqueue_op(input int op);
        logic is_store;
        is_store = (op_kind == OP_STORE);
        enq_valid      = 1'b1;
        enq_is_store   = is_store;
        enq_rob_tag    = op_rob;
        enq_size       = op_size;
        enq_unsigned   = op_unsigned;
        // producer tag zero means the data rides with the entry
        enq_data_valid = is_store && (op_dtag == '0);
        enq_data       = enq_data_valid ? op_sdata : '0;
        enq_data_tag   = op_dtag;
        tick();
        enq_valid  = 1'b0;
        addr_valid = 1'b1;
        addr_tag   = op_rob;
        addr       = op_addr;
        tick();
        addr_valid = 1'b0;
        pending.push_back(op);
        check_flag("lsq_free", lsq_free, pending.size() < `LSQ_DEPTH);
    endtask

    task automatic serve_load();
        int latency;
        logic [`DC_TAG_W-1:0] miss_tag;
        wait_request("a load request");
        check_request(`BUS_LOAD, op_addr, op_size, '0, 1'b0);
        hold_request(`BUS_LOAD, '0, 1'b0);
        if (op_hit) begin
            dcache_hit      = 1'b1;
            dcache_data_out = op_line;
            tick();
            dcache_hit      = 1'b0;
            dcache_data_out = '0;
        end else begin
            miss_tag = next_dc_tag;
            advance_dc_tag();
            dcache_response = miss_tag;
            tick();
            dcache_response = '0;
            // queue stays silent through a latency of 1 to 8 cycles
            draw_bits(3, latency);
            repeat (latency + 1) begin
                check_idle("while a miss is pending");
                check_flag("load_valid during a miss", load_valid, 1'b0);
                tick();
            end
            dcache_tag      = miss_tag;
            dcache_data_out = op_line;
            tick();
            dcache_tag      = '0;
            dcache_data_out = '0;
        end
        check_load(op_rob, op_expect[`XLEN-1:0]);
        tick();
        check_flag("load_valid one cycle later", load_valid, 1'b0);
    endtask

    task automatic serve_store();
        if (op_dtag != '0) begin
            check_flag("store_ready before its data", store_ready, 1'b0);
            cdb_valid = 1'b1;
            cdb_tag   = op_dtag;
            cdb_value = op_sdata;
            tick();
            cdb_valid = 1'b0;
        end
        wait_store_ready();
        check_store_ready(op_rob);
        repeat (3) begin
            check_idle("before the store retired");
            tick();
        end
        check_store_ready(op_rob);
        retire_valid = 1'b1;
        retire_tag   = op_rob;
        tick();
        retire_valid = 1'b0;
        wait_request("a store request");
        check_request(`BUS_STORE, op_addr, op_size, op_expect, 1'b1);
        hold_request(`BUS_STORE, op_expect, 1'b1);
        dcache_response = next_dc_tag;
        advance_dc_tag();
        tick();
        dcache_response = '0;
    endtask

    // everything queued leaves in queue order
    task automatic serve_batch();
        int op;
        while (pending.size() > 0) begin
            op = pending.pop_front();
            fetch_op(op);
            if (op_kind == OP_STORE) begin
                serve_store();
            end else begin
                serve_load();
            end
            check_flag("lsq_free after a pop", lsq_free, 1'b1);
        end
    endtask

    initial begin
        int op;
        reset           = 1'b1;
        enq_valid       = 1'b0;
        enq_is_store    = 1'b0;
        enq_rob_tag     = '0;
        enq_size        = '0;
        enq_unsigned    = 1'b0;
        enq_data_valid  = 1'b0;
        enq_data        = '0;
        enq_data_tag    = '0;
        addr_valid      = 1'b0;
        addr_tag        = '0;
        addr            = '0;
        cdb_valid       = 1'b0;
        cdb_tag         = '0;
        cdb_value       = '0;
        retire_valid    = 1'b0;
        retire_tag      = '0;
        dcache_response = '0;
        dcache_hit      = 1'b0;
        dcache_tag      = '0;
        dcache_data_out = '0;
        lfsr_state      = 16'd27974;
        next_dc_tag     = 4'h1;
        // unread slots decode as an unknown kind
        for (int i = 0; i < TRACE_OPS*TRACE_COLS; i++) begin
            trace_mem[i] = {i, 32'hffff_ffff};
        end
        $readmemh("tb/lsq_trace.txt", trace_mem);
        repeat (16) @(negedge clk);
        reset = 1'b0;
        tick();
        check_flag("load_valid after reset", load_valid, 1'b0);
        check_flag("store_ready after reset", store_ready, 1'b0);
        check_flag("lsq_free after reset", lsq_free, 1'b1);
        check_idle("after reset");
        op = 0;
        fetch_op(op);
        while (op_kind != OP_END) begin
            case (op_kind)
                OP_LOAD, OP_STORE: enqueue_op(op);
                OP_SERVE: serve_batch();
                default: stop_with_failure($sformatf("unknown kind in trace line %0d", op));
            endcase
            op++;
            if (op == TRACE_OPS) begin
                stop_with_failure("trace has no end line");
            end
            fetch_op(op);
        end
        if (pending.size() != 0) begin
            stop_with_failure("trace ended with operations still in the queue");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== tb/lsq_trace.txt ====
// kind rob_tag addr size unsigned store_data data_tag line hit expected (all hex)
// kind 1 load, 2 store, 3 serve queued batch, 0 end; expected is load value or store line
// signed bytes at every offset, fills the queue
1 00 00001000 0 0 00000000 00 7162D3C435269788 1 FFFFFF88
1 01 00001001 0 0 00000000 00 7162D3C435269788 1 FFFFFF97
1 02 00001002 0 0 00000000 00 7162D3C435269788 1 00000026
1 03 00001003 0 0 00000000 00 7162D3C435269788 1 00000035
1 04 00001004 0 0 00000000 00 7162D3C435269788 1 FFFFFFC4
1 05 00001005 0 0 00000000 00 7162D3C435269788 1 FFFFFFD3
1 06 00001006 0 0 00000000 00 7162D3C435269788 1 00000062
1 07 00001007 0 0 00000000 00 7162D3C435269788 1 00000071
3 0 0 0 0 0 0 0 0 0
// unsigned bytes at every offset
1 08 000020F8 0 1 00000000 00 7162D3C435269788 1 00000088
1 09 000020F9 0 1 00000000 00 7162D3C435269788 1 00000097
1 0A 000020FA 0 1 00000000 00 7162D3C435269788 1 00000026
1 0B 000020FB 0 1 00000000 00 7162D3C435269788 1 00000035
1 0C 000020FC 0 1 00000000 00 7162D3C435269788 1 000000C4
1 0D 000020FD 0 1 00000000 00 7162D3C435269788 1 000000D3
1 0E 000020FE 0 1 00000000 00 7162D3C435269788 1 00000062
1 0F 000020FF 0 1 00000000 00 7162D3C435269788 1 00000071
3 0 0 0 0 0 0 0 0 0
// halves, signed then unsigned
1 10 00003010 1 0 00000000 00 7162D3C435269788 1 FFFF9788
1 11 00003012 1 0 00000000 00 7162D3C435269788 1 00003526
1 12 00003014 1 0 00000000 00 7162D3C435269788 1 FFFFD3C4
1 13 00003016 1 0 00000000 00 7162D3C435269788 1 00007162
1 14 00003A20 1 1 00000000 00 7162D3C435269788 1 00009788
1 15 00003A22 1 1 00000000 00 7162D3C435269788 1 00003526
1 16 00003A24 1 1 00000000 00 7162D3C435269788 1 0000D3C4
1 17 00003A26 1 1 00000000 00 7162D3C435269788 1 00007162
3 0 0 0 0 0 0 0 0 0
// words
1 18 00004000 2 0 00000000 00 7162D3C435269788 1 35269788
1 19 00004004 2 0 00000000 00 7162D3C435269788 1 7162D3C4
1 1A 0000400C 2 1 00000000 00 7162D3C435269788 1 7162D3C4
3 0 0 0 0 0 0 0 0 0
// misses queued back to back
1 1B 00005005 0 0 00000000 00 8899AABBCCDDEEFF 0 FFFFFFAA
1 1C 00005102 1 1 00000000 00 8899AABBCCDDEEFF 0 0000CCDD
1 1D 00005202 1 0 00000000 00 0123456789ABCDEF 0 FFFF89AB
1 1E 00005304 2 0 00000000 00 0123456789ABCDEF 0 01234567
3 0 0 0 0 0 0 0 0 0
// store with data from the CDB
2 1F 00006008 2 0 DEADBEEF 0B 0000000000000000 0 00000000DEADBEEF
3 0 0 0 0 0 0 0 0 0
// loads behind stores
2 00 00007002 1 0 0000ABCD 00 0000000000000000 0 000000000000ABCD
1 01 00007002 1 1 00000000 00 00000000ABCD0000 1 0000ABCD
2 02 00007007 0 0 000000FF 03 0000000000000000 0 00000000000000FF
1 03 00007007 0 0 00000000 00 FF00000000000000 0 FFFFFFFF
3 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
